//--- common/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;   // 2 KB, bits 10:8 go in the control byte
    typedef logic [7:0]  eeprom_byte_t;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_t;

    // bit engine commands
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } bit_cmd_t;

    localparam logic [3:0] DEV_TYPE = 4'b1010;

    localparam int SCL_QUARTER = 4;   // CLK cycles per quarter SCL period, 2 or more
    localparam int QCNT_W      = $clog2(SCL_QUARTER);

endpackage

`default_nettype wire

//--- common/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_ADDR   = 8'h04;
    localparam apb_addr_t REG_WDATA  = 8'h08;
    localparam apb_addr_t REG_RDATA  = 8'h0C;   // read only
    localparam apb_addr_t REG_STATUS = 8'h10;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_READ_BIT  = 1;

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;   // sticky
    localparam int STAT_NACK_BIT = 2;   // sticky

endpackage

`default_nettype wire

//--- common/i2c_bit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i2c_bit_if;
    import eeprom_pkg::*;

    bit_cmd_t     cmd;
    eeprom_byte_t tx_byte;
    logic         tx_nack;   // ack bit the master sends after a read byte
    logic         valid;
    logic         ready;     // one cycle, command finished
    eeprom_byte_t rx_byte;
    logic         rx_nack;   // sampled ack bit of the last byte slot

    modport seq (
        output cmd, tx_byte, tx_nack, valid,
        input  ready, rx_byte, rx_nack
    );

    modport eng (
        input  cmd, tx_byte, tx_nack, valid,
        output ready, rx_byte, rx_nack
    );

endinterface

`default_nettype wire

//--- eeprom_ctrl/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer (
    input  wire                           CLK,
    input  wire                           RESET,
    input  wire                           go,
    input  wire eeprom_pkg::eeprom_op_t   op,
    input  wire eeprom_pkg::eeprom_addr_t addr,
    input  wire eeprom_pkg::eeprom_byte_t wdata,
    output logic                          busy,
    output logic                          done,
    output logic                          nack,
    output eeprom_pkg::eeprom_byte_t      rdata,
    i2c_bit_if.seq                        bus
);
    import eeprom_pkg::*;

    typedef enum logic [8:0]
    {
        S_IDLE   = 9'b0_0000_0001,
        S_START  = 9'b0_0000_0010,
        S_CTRL_W = 9'b0_0000_0100,
        S_ADDR   = 9'b0_0000_1000,
        S_DATA_W = 9'b0_0001_0000,
        S_RSTART = 9'b0_0010_0000,
        S_CTRL_R = 9'b0_0100_0000,
        S_DATA_R = 9'b0_1000_0000,
        S_STOP   = 9'b1_0000_0000
    } state_t;

    state_t       state;
    bit_cmd_t     cmd_next;
    eeprom_byte_t byte_next;
    logic         launch;
    logic         ack_fail;

    // one command per state, issued while valid is low
    assign launch   = (state != S_IDLE) && !bus.valid;
    assign ack_fail = bus.rx_nack && (bus.cmd == CMD_WRITE);
    assign busy     = (state != S_IDLE) || done;

    always_comb
    begin
        cmd_next  = CMD_WRITE;
        byte_next = '0;
        case (state)
            S_START, S_RSTART: cmd_next = CMD_START;
            S_CTRL_W: byte_next = {DEV_TYPE, addr[10:8], 1'b0};
            S_ADDR:   byte_next = addr[7:0];
            S_DATA_W: byte_next = wdata;
            S_CTRL_R: byte_next = {DEV_TYPE, addr[10:8], 1'b1};
            S_DATA_R: cmd_next = CMD_READ;
            S_STOP:   cmd_next = CMD_STOP;
            default:  ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            bus.valid <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == S_IDLE)
            begin
                if (go)
                begin
                    nack  <= 1'b0;
                    state <= S_START;
                end
            end
            else if (launch)
                bus.valid <= 1'b1;
            else if (bus.ready)
            begin
                bus.valid <= 1'b0;
                if (ack_fail)
                    nack <= 1'b1;   // slave refused a byte
                case (state)
                    S_START:  state <= S_CTRL_W;
                    S_CTRL_W: state <= ack_fail ? S_STOP : S_ADDR;
                    S_ADDR:
                    begin
                        if (ack_fail)
                            state <= S_STOP;
                        else if (op == OP_READ)
                            state <= S_RSTART;
                        else
                            state <= S_DATA_W;
                    end
                    S_DATA_W: state <= S_STOP;
                    S_RSTART: state <= S_CTRL_R;
                    S_CTRL_R: state <= ack_fail ? S_STOP : S_DATA_R;
                    S_DATA_R: state <= S_STOP;
                    S_STOP:
                    begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                    default:  state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (launch)
        begin
            bus.cmd     <= cmd_next;
            bus.tx_byte <= byte_next;
            bus.tx_nack <= (state == S_DATA_R);   // single byte read ends with NACK
        end
        if (bus.ready && (state == S_DATA_R))
            rdata <= bus.rx_byte;
    end

endmodule

`default_nettype wire

//--- eeprom_ctrl/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  wire    CLK,
    input  wire    RESET,
    i2c_bit_if.eng bus,
    output logic   scl,
    inout  wire    sda
);
    import eeprom_pkg::*;

    logic              active;
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        quarter;   // 0 low, 1 high, 2 high, 3 low for byte slots
    logic [3:0]        bit_idx;   // 8 is the ack slot
    bit_cmd_t          cmd_r;
    eeprom_byte_t      shreg;
    logic              tx_nack_r;
    logic              sda_low;
    logic              is_byte;
    logic              last_slot;

    assign sda         = sda_low ? 1'b0 : 1'bz;   // open drain
    assign bus.rx_byte = shreg;
    assign is_byte     = (cmd_r == CMD_WRITE) || (cmd_r == CMD_READ);
    assign last_slot   = !is_byte || (bit_idx == 4'd8);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active      <= 1'b0;
            bus.ready   <= 1'b0;
            bus.rx_nack <= 1'b0;
            qcnt        <= '0;
            quarter     <= '0;
            bit_idx     <= '0;
            scl         <= 1'b1;
            sda_low     <= 1'b0;
        end
        else
        begin
            bus.ready <= 1'b0;
            if (!active)
            begin
                if (bus.valid && !bus.ready)
                begin
                    active  <= 1'b1;
                    qcnt    <= '0;
                    quarter <= '0;
                    bit_idx <= '0;
                    shreg   <= bus.tx_byte;
                    scl     <= 1'b0;   // every command opens with SCL low
                    sda_low <= (bus.cmd == CMD_STOP) ||
                               ((bus.cmd == CMD_WRITE) && !bus.tx_byte[7]);
                end
            end
            else if (qcnt != QCNT_W'(SCL_QUARTER - 1))
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt    <= '0;
                quarter <= quarter + 1'b1;
                case (quarter)
                    2'd0: scl <= 1'b1;
                    2'd1:
                    begin
                        // SCL high midpoint
                        if (cmd_r == CMD_START)
                            sda_low <= 1'b1;
                        else if (cmd_r == CMD_STOP)
                            sda_low <= 1'b0;
                        else if (bit_idx == 4'd8)
                            bus.rx_nack <= sda;
                        else
                            shreg <= {shreg[6:0], sda};
                    end
                    2'd2:
                    begin
                        if (cmd_r != CMD_STOP)
                            scl <= 1'b0;
                    end
                    default:
                    begin
                        if (last_slot)
                        begin
                            active    <= 1'b0;
                            bus.ready <= 1'b1;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == 4'd7)
                                sda_low <= (cmd_r == CMD_READ) && !tx_nack_r;
                            else
                                sda_low <= (cmd_r == CMD_WRITE) && !shreg[7];
                        end
                    end
                endcase
            end
        end
    end

    // command payload
    always_ff @(posedge CLK)
    begin
        if (!active && bus.valid && !bus.ready)
        begin
            cmd_r     <= bus.cmd;
            tx_nack_r <= bus.tx_nack;
        end
    end

endmodule

`default_nettype wire

//--- verilog/apb_eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_eeprom_regs (
    input  wire                           CLK,
    input  wire                           RESET,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire apb_regs_pkg::apb_addr_t  paddr,
    input  wire apb_regs_pkg::apb_data_t  pwdata,
    output apb_regs_pkg::apb_data_t       prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          go,
    output eeprom_pkg::eeprom_op_t        op,
    output eeprom_pkg::eeprom_addr_t      addr,
    output eeprom_pkg::eeprom_byte_t      wdata,
    input  wire                           busy,
    input  wire                           done,
    input  wire                           nack,
    input  wire eeprom_pkg::eeprom_byte_t rdata
);
    import apb_regs_pkg::*;
    import eeprom_pkg::*;

    logic         access;
    logic         wr_access;
    logic         start_req;
    logic         mapped;
    logic         done_r;
    logic         nack_r;
    eeprom_byte_t rdata_r;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign start_req = wr_access && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
    assign go        = start_req && !busy;
    assign pready    = 1'b1;   // zero wait
    assign pslverr   = access && (!mapped || (start_req && busy));

    always_comb
    begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL:   prdata[CTRL_READ_BIT] = op;
            REG_ADDR:   prdata[$bits(eeprom_addr_t)-1:0] = addr;
            REG_WDATA:  prdata[$bits(eeprom_byte_t)-1:0] = wdata;
            REG_RDATA:  prdata[$bits(eeprom_byte_t)-1:0] = rdata_r;
            REG_STATUS:
            begin
                prdata[STAT_BUSY_BIT] = busy;
                prdata[STAT_DONE_BIT] = done_r;
                prdata[STAT_NACK_BIT] = nack_r;
            end
            default:    mapped = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            op     <= OP_WRITE;
            done_r <= 1'b0;
            nack_r <= 1'b0;
        end
        else if (go)
        begin
            op     <= eeprom_op_t'(pwdata[CTRL_READ_BIT]);
            done_r <= 1'b0;   // new transaction clears sticky bits
            nack_r <= 1'b0;
        end
        else if (done)
        begin
            done_r <= 1'b1;
            nack_r <= nack;
        end
    end

    // address and data stay frozen while a transaction runs
    always_ff @(posedge CLK)
    begin
        if (wr_access && !busy && (paddr == REG_ADDR))
            addr <= pwdata[$bits(eeprom_addr_t)-1:0];
        if (wr_access && !busy && (paddr == REG_WDATA))
            wdata <= pwdata[$bits(eeprom_byte_t)-1:0];
        if (done)
            rdata_r <= rdata;
    end

endmodule

`default_nettype wire

//--- verilog/eeprom_apb_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_apb_top (
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire apb_regs_pkg::apb_addr_t paddr,
    input  wire apb_regs_pkg::apb_data_t pwdata,
    output apb_regs_pkg::apb_data_t      prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         scl,
    inout  wire                          sda
);
    import eeprom_pkg::*;

    logic         go;
    eeprom_op_t   op;
    eeprom_addr_t addr;
    eeprom_byte_t wdata;
    logic         busy;
    logic         done;
    logic         nack;
    eeprom_byte_t rdata;

    i2c_bit_if bit_bus ();

    apb_eeprom_regs i_apb_eeprom_regs (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .go      (go),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .rdata   (rdata)
    );

    eeprom_sequencer i_eeprom_sequencer (
        .CLK   (CLK),
        .RESET (RESET),
        .go    (go),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .done  (done),
        .nack  (nack),
        .rdata (rdata),
        .bus   (bit_bus.seq)
    );

    i2c_bit_engine i_i2c_bit_engine (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (bit_bus.eng),
        .scl   (scl),
        .sda   (sda)
    );

endmodule

`default_nettype wire

//--- tb/i2c_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_model (
    input  wire scl,
    inout  wire sda,
    input  wire nack_en   // refuse the control byte
);
    import eeprom_pkg::*;

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_READ} model_state_t;

    eeprom_byte_t mem [0:2047];
    model_state_t state = M_IDLE;
    int           bit_cnt = 0;   // SCL rising edges in this byte slot
    eeprom_byte_t shreg = '0;
    eeprom_byte_t tx_byte = '0;
    eeprom_addr_t ptr = '0;
    logic         drive_low = 1'b0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    task automatic preload(input eeprom_addr_t a, input eeprom_byte_t d);
        mem[a] = d;
    endtask

    // start condition
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state   = M_CTRL;
            bit_cnt = 0;
        end
    end

    // stop condition
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_IDLE;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (bit_cnt < 8)
                shreg = {shreg[6:0], sda};
            else if ((state == M_READ) && (sda !== 1'b0))
                state = M_IDLE;   // master NACK ends the read
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (bit_cnt == 8)
            begin
                drive_low = 1'b1;
                case (state)
                    M_CTRL:
                    begin
                        if ((shreg[7:4] != DEV_TYPE) || nack_en)
                        begin
                            drive_low = 1'b0;
                            state     = M_IDLE;
                        end
                        else
                        begin
                            ptr[10:8] = shreg[3:1];   // block select
                            state     = shreg[0] ? M_READ : M_ADDR;
                        end
                    end
                    M_ADDR:
                    begin
                        ptr[7:0] = shreg;
                        state    = M_DATA;
                    end
                    M_DATA:
                    begin
                        mem[ptr] = shreg;
                        ptr[7:0] = ptr[7:0] + 8'd1;
                    end
                    default: drive_low = 1'b0;   // ack slot belongs to the master
                endcase
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt   = 0;
                drive_low = 1'b0;
                if (state == M_READ)
                begin
                    tx_byte   = mem[ptr];
                    ptr       = ptr + 11'd1;
                    drive_low = !tx_byte[7];
                end
            end
            else if (state == M_READ)
                drive_low = !tx_byte[7 - bit_cnt];
        end
    end

endmodule

`default_nettype wire

//--- tb/eeprom_apb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_apb_sva (
    input wire                       CLK,
    input wire                       RESET,
    input wire                       go,
    input wire                       busy,
    input wire                       valid,
    input wire                       ready,
    input wire eeprom_pkg::bit_cmd_t cmd
);
    int failures = 0;

    // command held until the engine finishes it
    valid_held: assert property (@(posedge CLK) disable iff (RESET)
        (valid && !ready) |=> (valid && $stable(cmd)))
    else
    begin
        failures++;
        $error("bit engine request dropped or changed before ready");
    end

    // an accepted go makes the sequencer busy
    go_starts_busy: assert property (@(posedge CLK) disable iff (RESET)
        go |=> busy)
    else
    begin
        failures++;
        $error("go was not followed by busy");
    end

    idle_after_reset: assert property (@(posedge CLK)
        RESET |=> !busy)
    else
    begin
        failures++;
        $error("busy set right after reset");
    end

endmodule

bind eeprom_sequencer eeprom_apb_sva i_eeprom_apb_sva (
    .CLK   (CLK),
    .RESET (RESET),
    .go    (go),
    .busy  (busy),
    .valid (bus.valid),
    .ready (bus.ready),
    .cmd   (bus.cmd)
);

`default_nettype wire

//--- tb/tb_eeprom_apb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_apb;
    import apb_regs_pkg::*;
    import eeprom_pkg::*;

    localparam int CYCLES_PER_TEST = 2000;
    localparam int MEM_BYTES       = 2048;

    logic      CLK;
    logic      RESET;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    wire       scl;
    wire       sda;
    logic      nack_en;

    eeprom_byte_t shadow [0:MEM_BYTES-1];   // expected memory contents
    string        kinds [$];
    apb_data_t    addrs [$];
    apb_data_t    datas [$];
    apb_data_t    exps [$];
    int           n_tests;
    bit           tests_loaded;

    pullup (scl);
    pullup (sda);

    eeprom_apb_top i_eeprom_apb_top (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda     (sda)
    );

    i2c_eeprom_model eeprom (
        .scl     (scl),
        .sda     (sda),
        .nack_en (nack_en)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic report_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input eeprom_pkg::eeprom_byte_t expected,
                              input eeprom_pkg::eeprom_byte_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s read data expected %02h actual %02h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_status(input string name, input apb_regs_pkg::apb_data_t expected,
                                input apb_regs_pkg::apb_data_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s register value expected %08h actual %08h",
                     name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_err(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s pslverr expected %b actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    // zero wait slave keeps pready high in every access phase
    task automatic check_ready(input apb_addr_t a, input logic actual);
        if (actual !== 1'b1)
        begin
            $display("pready was low in the access phase at offset %02h", a);
            report_failure();
        end
    endtask

    task automatic apb_write(input apb_addr_t a, input apb_data_t d, output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        paddr   <= a;
        pwdata  <= d;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        err = pslverr;
        check_ready(a, pready);
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t a, output apb_data_t d, output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        paddr   <= a;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        d   = prdata;
        err = pslverr;
        check_ready(a, pready);
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic apb_data_t ctrl_word(input eeprom_op_t op);
        apb_data_t w;
        w                 = '0;
        w[CTRL_START_BIT] = 1'b1;
        w[CTRL_READ_BIT]  = (op == OP_READ);
        return w;
    endfunction

    task automatic start_op(input string name, input eeprom_addr_t a, input eeprom_byte_t d,
                            input eeprom_op_t op);
        logic err;
        apb_write(REG_ADDR, apb_data_t'(a), err);
        check_err(name, 1'b0, err);
        apb_write(REG_WDATA, apb_data_t'(d), err);
        check_err(name, 1'b0, err);
        apb_write(REG_CTRL, ctrl_word(op), err);
        check_err(name, 1'b0, err);
    endtask

    // poll until the sticky done bit shows up
    task automatic wait_done(output apb_data_t status);
        logic err;
        status = '0;
        while (!status[STAT_DONE_BIT])
            apb_read(REG_STATUS, status, err);
    endtask

    task automatic load_tests();
        int        fd;
        string     line;
        string     kind;
        apb_data_t a;
        apb_data_t d;
        apb_data_t e;
        fd = $fopen("tb/eeprom_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the test data file tb/eeprom_testdata.txt");
            report_failure();
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if ((line.len() > 1) && (line.getc(0) != "#"))
                begin
                    if ($sscanf(line, "%s %h %h %h", kind, a, d, e) == 4)
                    begin
                        kinds.push_back(kind);
                        addrs.push_back(a);
                        datas.push_back(d);
                        exps.push_back(e);
                    end
                end
            end
            $fclose(fd);
            n_tests      = kinds.size();
            tests_loaded = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        string        name;
        eeprom_addr_t a;
        eeprom_byte_t d;
        apb_data_t    e;
        apb_data_t    status;
        apb_data_t    value;
        logic         err;
        name = $sformatf("test %0d %s", idx + 1, kinds[idx]);
        a    = addrs[idx][10:0];
        d    = datas[idx][7:0];
        e    = exps[idx];
        case (kinds[idx])
            "wr":
            begin
                start_op(name, a, d, OP_WRITE);
                wait_done(status);
                check_status(name, e, status);
                shadow[a] = d;
            end
            "rd":
            begin
                start_op(name, a, d, OP_READ);
                wait_done(status);
                check_status(name, e, status);
                apb_read(REG_RDATA, value, err);
                check_err(name, 1'b0, err);
                check_byte(name, shadow[a], value[7:0]);
            end
            "nack":
            begin
                nack_en = 1'b1;   // slave refuses, memory keeps the old byte
                start_op(name, a, d, OP_WRITE);
                wait_done(status);
                nack_en = 1'b0;
                check_status(name, e, status);
            end
            "busyerr":
            begin
                start_op(name, a, d, OP_WRITE);
                apb_write(REG_CTRL, ctrl_word(OP_READ), err);
                check_err(name, e[0], err);
                wait_done(status);
                check_status(name, apb_data_t'(1) << STAT_DONE_BIT, status);
                shadow[a] = d;
            end
            "unmapped":
            begin
                apb_read(addrs[idx][7:0], value, err);
                check_err(name, e[0], err);
                check_status(name, '0, value);
                apb_write(addrs[idx][7:0], datas[idx], err);
                check_err(name, e[0], err);
            end
            default:
            begin
                $display("unknown test kind %s in the test data file", kinds[idx]);
                report_failure();
            end
        endcase
    endtask

    initial
    begin
        apb_data_t status;
        logic      err;
        int        i;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        RESET        = 1'b1;
        nack_en      = 1'b0;
        void'($urandom(32'hba68_0398));
        for (i = 0; i < MEM_BYTES; i++)
        begin
            shadow[i] = eeprom_byte_t'($urandom);
            eeprom.preload(eeprom_addr_t'(i), shadow[i]);
        end
        load_tests();
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        apb_read(REG_STATUS, status, err);
        check_err("after reset", 1'b0, err);
        check_status("after reset", '0, status);
        for (i = 0; i < n_tests; i++)
            run_test(i);
        if (i_eeprom_apb_top.i_eeprom_sequencer.i_eeprom_apb_sva.failures == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("assertions in the sequencer reported a failure");
            report_failure();
        end
    end

    // limit scales with the number of tests
    initial
    begin
        wait (tests_loaded);
        repeat (n_tests * CYCLES_PER_TEST) @(posedge CLK);
        $display("timeout, a transaction never completed within %0d clock cycles",
                 n_tests * CYCLES_PER_TEST);
        report_failure();
    end

endmodule

`default_nettype wire

//--- all.f
common/eeprom_pkg.sv
common/apb_regs_pkg.sv
common/i2c_bit_if.sv
eeprom_ctrl/eeprom_sequencer.sv
eeprom_ctrl/i2c_bit_engine.sv
verilog/apb_eeprom_regs.sv
verilog/eeprom_apb_top.sv
tb/i2c_eeprom_model.sv
tb/eeprom_apb_sva.sv
tb/tb_eeprom_apb.sv

//--- tb/eeprom_testdata.txt
# kind  addr(hex) data(hex) expect(hex)
# expect is the status for wr/rd/nack and pslverr for busyerr/unmapped
wr       123  5a  2
rd       123  00  2
wr       023  a5  2
wr       723  3c  2
rd       023  00  2
rd       723  00  2
rd       123  00  2
rd       456  00  2
nack     123  ff  6
rd       123  00  2
busyerr  7ff  c3  1
rd       7ff  00  2
unmapped 014  00  1
unmapped 0fc  00  1
